// ==== logic/simd_alu_top.sv ====
/*
 * Packed-SIMD arithmetic unit top level
 * Adder, comparator and shifter lanes with a one-cycle registered response
 */
module simd_alu_top (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                req_valid_i,
  input  simd_pkg::simd_req_t req_i,
  output logic                rsp_valid_o,
  output simd_pkg::simd_rsp_t rsp_o
);

  localparam int unsigned XLEN = simd_pkg::XLEN;

  logic [XLEN-1:0]       adder_sum;
  simd_pkg::lane_flags_t adder_carry;
  logic [XLEN-1:0]       adder_result;
  logic                  adder_overflow;
  logic [XLEN-1:0]       compare_result;
  logic [XLEN-1:0]       shift_result;
  simd_pkg::simd_rsp_t   rsp_d;

  ////////////////////////////////////////////////////////////////////////////
  // Lane datapaths
  ////////////////////////////////////////////////////////////////////////////

  simd_lane_adder simd_lane_adder_i (
    .req_i      (req_i),
    .sum_o      (adder_sum),
    .carry_o    (adder_carry),
    .result_o   (adder_result),
    .overflow_o (adder_overflow)
  );

  // Compare works on the adder difference
  simd_lane_compare simd_lane_compare_i (
    .req_i    (req_i),
    .sum_i    (adder_sum),
    .carry_i  (adder_carry),
    .result_o (compare_result)
  );

  simd_lane_shifter simd_lane_shifter_i (
    .req_i    (req_i),
    .result_o (shift_result)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Result select and response register
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    unique case (req_i.op)
      simd_pkg::OP_ADD,  simd_pkg::OP_SUB,
      simd_pkg::OP_HADD, simd_pkg::OP_HSUB,
      simd_pkg::OP_SADD, simd_pkg::OP_SSUB:  rsp_d.result = adder_result;

      simd_pkg::OP_CMPEQ, simd_pkg::OP_CMPLT,
      simd_pkg::OP_CMPLE, simd_pkg::OP_MIN,
      simd_pkg::OP_MAX:                      rsp_d.result = compare_result;

      simd_pkg::OP_SLL, simd_pkg::OP_SRL,
      simd_pkg::OP_SRA:                      rsp_d.result = shift_result;

      default:                               rsp_d.result = '0;
    endcase
    // Adder only raises this on saturating ops
    rsp_d.overflow = adder_overflow;
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rsp_valid_o <= 1'b0;
      rsp_o       <= '0;
    end else begin
      rsp_valid_o <= req_valid_i;
      if (req_valid_i) begin
        rsp_o <= rsp_d;
      end
    end
  end

endmodule

// ==== logic/simd_lane_adder.sv ====
/*
 * Byte-sliced SIMD adder
 * Carry chain is cut at lane edges; gives wrapping, halving and saturating results
 */
module simd_lane_adder (
  input  simd_pkg::simd_req_t       req_i,
  output logic [simd_pkg::XLEN-1:0] sum_o,
  output simd_pkg::lane_flags_t     carry_o,
  output logic [simd_pkg::XLEN-1:0] result_o,
  output logic                      overflow_o
);

  localparam int unsigned XLEN = simd_pkg::XLEN;
  localparam int unsigned BW   = simd_pkg::BYTE_W;
  localparam int unsigned NB   = simd_pkg::NUM_BYTES;

  logic                       sub;
  logic                       half_op;
  logic                       sat_op;
  simd_pkg::lane_flags_t      lane_top;
  simd_pkg::lane_flags_t      lane_start;
  simd_pkg::lane_flags_t      carry_in;
  simd_pkg::lane_flags_t      ext;
  simd_pkg::lane_flags_t      clamp_top;
  simd_pkg::lane_flags_t      clamp;
  simd_pkg::lane_flags_t      lane_ext;
  logic [NB-1:0][BW:0]        slice;
  logic [XLEN-1:0]            operand_b_x;
  logic [XLEN-1:0]            half_result;
  logic [XLEN-1:0]            sat_result;

  ////////////////////////////////////////////////////////////////////////////
  // Op decode
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    unique case (req_i.op)
      simd_pkg::OP_SUB,   simd_pkg::OP_HSUB,  simd_pkg::OP_SSUB,
      simd_pkg::OP_CMPEQ, simd_pkg::OP_CMPLT, simd_pkg::OP_CMPLE,
      simd_pkg::OP_MIN,   simd_pkg::OP_MAX: sub = 1'b1;
      default:                              sub = 1'b0;
    endcase
  end

  assign half_op = (req_i.op == simd_pkg::OP_HADD) || (req_i.op == simd_pkg::OP_HSUB);
  assign sat_op  = (req_i.op == simd_pkg::OP_SADD) || (req_i.op == simd_pkg::OP_SSUB);

  // Top byte of every lane
  always_comb begin
    unique case (req_i.width)
      simd_pkg::LW_8:  lane_top = 4'b1111;
      simd_pkg::LW_16: lane_top = 4'b1010;
      default:         lane_top = 4'b1000;
    endcase
  end

  // A lane starts right above the previous lane's top byte
  assign lane_start = {lane_top[NB-2:0], 1'b1};

  ////////////////////////////////////////////////////////////////////////////
  // Sliced adder
  ////////////////////////////////////////////////////////////////////////////

  assign operand_b_x = sub ? ~req_i.operand_b : req_i.operand_b;

  always_comb begin
    carry_in[0] = sub;
    slice[0]    = {1'b0, req_i.operand_a[BW-1:0]} + {1'b0, operand_b_x[BW-1:0]}
                + {{BW{1'b0}}, carry_in[0]};
    for (int i = 1; i < NB; i++) begin
      // Chain breaks here when a new lane begins
      carry_in[i] = lane_start[i] ? sub : slice[i-1][BW];
      slice[i]    = {1'b0, req_i.operand_a[BW*i +: BW]} + {1'b0, operand_b_x[BW*i +: BW]}
                  + {{BW{1'b0}}, carry_in[i]};
    end
  end

  always_comb begin
    for (int i = 0; i < NB; i++) begin
      sum_o[BW*i +: BW] = slice[i][BW-1:0];
      carry_o[i]        = slice[i][BW];
      // Extra bit of the full-precision result, valid at lane tops
      ext[i] = (req_i.is_signed & req_i.operand_a[BW*i+BW-1])
             ^ (req_i.is_signed & req_i.operand_b[BW*i+BW-1])
             ^ sub ^ slice[i][BW];
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Halving and saturation
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    half_result = {1'b0, sum_o[XLEN-1:1]};
    for (int i = 0; i < NB; i++) begin
      if (lane_top[i]) begin
        half_result[BW*i+BW-1] = ext[i];
      end
    end
  end

  // Signed clamps when the two top bits disagree, unsigned on carry or borrow
  always_comb begin
    for (int i = 0; i < NB; i++) begin
      clamp_top[i] = lane_top[i]
                   & (req_i.is_signed ? (ext[i] ^ slice[i][BW-1]) : ext[i]);
    end
  end

  assign clamp    = simd_pkg::lane_from_top(clamp_top, req_i.width);
  assign lane_ext = simd_pkg::lane_from_top(ext, req_i.width);

  always_comb begin
    logic [BW-1:0] sat_byte;
    for (int i = 0; i < NB; i++) begin
      // Signed min is 80..00, max 7f..ff; unsigned is all ones or zero
      if (req_i.is_signed) begin
        sat_byte[BW-2:0] = {(BW-1){~lane_ext[i]}};
        sat_byte[BW-1]   = lane_top[i] ^ ~lane_ext[i];
      end else begin
        sat_byte = {BW{~sub}};
      end
      sat_result[BW*i +: BW] = clamp[i] ? sat_byte : sum_o[BW*i +: BW];
    end
  end

  assign overflow_o = sat_op & (|clamp_top);

  always_comb begin
    if (half_op) begin
      result_o = half_result;
    end else if (sat_op) begin
      result_o = sat_result;
    end else begin
      result_o = sum_o;
    end
  end

endmodule

// ==== logic/simd_lane_compare.sv ====
/*
 * SIMD lane comparator
 * Equal/less lane masks from the adder difference, used for compares and min/max
 */
module simd_lane_compare (
  input  simd_pkg::simd_req_t       req_i,
  input  logic [simd_pkg::XLEN-1:0] sum_i,
  input  simd_pkg::lane_flags_t     carry_i,
  output logic [simd_pkg::XLEN-1:0] result_o
);

  localparam int unsigned BW = simd_pkg::BYTE_W;
  localparam int unsigned NB = simd_pkg::NUM_BYTES;

  simd_pkg::lane_flags_t byte_zero;
  simd_pkg::lane_flags_t byte_less;
  simd_pkg::lane_flags_t lane_eq;
  simd_pkg::lane_flags_t lane_lt;
  simd_pkg::lane_flags_t mask;

  // Per-byte flags; only the top byte of a lane carries a valid less flag
  always_comb begin
    logic a_msb;
    logic b_msb;
    for (int i = 0; i < NB; i++) begin
      a_msb        = req_i.operand_a[BW*i+BW-1];
      b_msb        = req_i.operand_b[BW*i+BW-1];
      byte_zero[i] = (sum_i[BW*i +: BW] == '0);
      if (req_i.is_signed) begin
        byte_less[i] = (a_msb == b_msb) ? sum_i[BW*i+BW-1] : a_msb;
      end else begin
        // Borrow out of the lane means a < b
        byte_less[i] = ~carry_i[i];
      end
    end
  end

  // Lane is equal only if every byte of the difference is zero
  always_comb begin
    unique case (req_i.width)
      simd_pkg::LW_8:  lane_eq = byte_zero;
      simd_pkg::LW_16: lane_eq = {{2{&byte_zero[3:2]}}, {2{&byte_zero[1:0]}}};
      default:         lane_eq = {NB{&byte_zero}};
    endcase
  end

  assign lane_lt = simd_pkg::lane_from_top(byte_less, req_i.width);

  always_comb begin
    unique case (req_i.op)
      simd_pkg::OP_CMPEQ: mask = lane_eq;
      simd_pkg::OP_CMPLE: mask = lane_eq | lane_lt;
      default:            mask = lane_lt;
    endcase
  end

  // Widen to all-ones lanes, or pick operand lanes for min/max
  always_comb begin
    for (int i = 0; i < NB; i++) begin
      unique case (req_i.op)
        simd_pkg::OP_MIN: result_o[BW*i +: BW] = mask[i] ? req_i.operand_a[BW*i +: BW]
                                                         : req_i.operand_b[BW*i +: BW];
        simd_pkg::OP_MAX: result_o[BW*i +: BW] = mask[i] ? req_i.operand_b[BW*i +: BW]
                                                         : req_i.operand_a[BW*i +: BW];
        default:          result_o[BW*i +: BW] = {BW{mask[i]}};
      endcase
    end
  end

endmodule

// ==== logic/simd_lane_shifter.sv ====
/*
 * SIMD lane shifter
 * Staged right shifter confined to lanes; left shifts run on lane-reversed data
 */
module simd_lane_shifter (
  input  simd_pkg::simd_req_t       req_i,
  output logic [simd_pkg::XLEN-1:0] result_o
);

  localparam int unsigned XLEN   = simd_pkg::XLEN;
  localparam int unsigned BW     = simd_pkg::BYTE_W;
  localparam int unsigned NB     = simd_pkg::NUM_BYTES;
  localparam int unsigned STAGES = 5;

  logic                      shift_left;
  logic                      shift_arith;
  logic [4:0]                pos_mask;
  simd_pkg::lane_flags_t     byte_msb;
  simd_pkg::lane_flags_t     lane_sign;
  logic [NB-1:0][4:0]        lane_amt;
  logic [XLEN-1:0]           shift_src;
  logic [XLEN-1:0]           fill_mask;
  logic [XLEN-1:0]           right_result;
  logic [STAGES:0][XLEN-1:0] stage_v;

  // Mirror bits inside each lane
  function automatic logic [XLEN-1:0] lane_reverse(input logic [XLEN-1:0] x,
                                                   input simd_pkg::lane_width_e w);
    logic [XLEN-1:0] r;
    for (int p = 0; p < XLEN; p++) begin
      unique case (w)
        simd_pkg::LW_8:  r[p] = x[(p / BW) * BW + BW - 1 - (p % BW)];
        simd_pkg::LW_16: r[p] = x[(p / (2*BW)) * (2*BW) + 2*BW - 1 - (p % (2*BW))];
        default:         r[p] = x[XLEN - 1 - p];
      endcase
    end
    return r;
  endfunction

  assign shift_left  = (req_i.op == simd_pkg::OP_SLL);
  assign shift_arith = (req_i.op == simd_pkg::OP_SRA);
  assign shift_src   = shift_left ? lane_reverse(req_i.operand_a, req_i.width)
                                  : req_i.operand_a;

  // Bit position inside a lane, and the amount taken from the same lane of B
  always_comb begin
    unique case (req_i.width)
      simd_pkg::LW_8:  pos_mask = 5'd7;
      simd_pkg::LW_16: pos_mask = 5'd15;
      default:         pos_mask = 5'd31;
    endcase
    for (int i = 0; i < NB; i++) begin
      unique case (req_i.width)
        simd_pkg::LW_8:  lane_amt[i] = {2'b00, req_i.operand_b[BW*i +: 3]};
        simd_pkg::LW_16: lane_amt[i] = {1'b0, req_i.operand_b[2*BW*(i/2) +: 4]};
        default:         lane_amt[i] = req_i.operand_b[4:0];
      endcase
      byte_msb[i] = req_i.operand_a[BW*i+BW-1];
    end
  end

  assign lane_sign = simd_pkg::lane_from_top(byte_msb, req_i.width);

  ////////////////////////////////////////////////////////////////////////////
  // Log shifter where stage k moves by 2**k when lane amount bit k is set
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    logic [XLEN-1:0] moved;
    logic [5:0]      reach;
    stage_v[0] = shift_src;
    for (int k = 0; k < STAGES; k++) begin
      moved = stage_v[k] >> (1 << k);
      for (int p = 0; p < XLEN; p++) begin
        reach = {1'b0, 5'(p) & pos_mask} + 6'(1 << k);
        if (!lane_amt[p / BW][k]) begin
          stage_v[k+1][p] = stage_v[k][p];
        end else if (reach > {1'b0, pos_mask}) begin
          // Source bit sits in the next lane up
          stage_v[k+1][p] = 1'b0;
        end else begin
          stage_v[k+1][p] = moved[p];
        end
      end
    end
  end

  // Thermometer of vacated bits below each lane top, filled with sign on SRA
  always_comb begin
    for (int p = 0; p < XLEN; p++) begin
      fill_mask[p]    = (pos_mask - (5'(p) & pos_mask)) < lane_amt[p / BW];
      right_result[p] = stage_v[STAGES][p] | (fill_mask[p] & shift_arith & lane_sign[p / BW]);
    end
  end

  assign result_o = shift_left ? lane_reverse(right_result, req_i.width) : right_result;

endmodule

// ==== logic/simd_pkg.sv ====
/*
 * Packed-SIMD arithmetic unit shared definitions
 * Register geometry, lane sizes, operation codes and request/response structs
 */
package simd_pkg;

  // Register geometry
  localparam int unsigned XLEN      = 32;
  localparam int unsigned BYTE_W    = 8;
  localparam int unsigned NUM_BYTES = XLEN / BYTE_W;

  // Lane size chosen per request
  typedef enum logic [1:0] {
    LW_8  = 2'd0,
    LW_16 = 2'd1,
    LW_32 = 2'd2
  } lane_width_e;

  typedef enum logic [3:0] {
    OP_ADD   = 4'd0,
    OP_SUB   = 4'd1,
    OP_HADD  = 4'd2,
    OP_HSUB  = 4'd3,
    OP_SADD  = 4'd4,
    OP_SSUB  = 4'd5,
    OP_CMPEQ = 4'd6,
    OP_CMPLT = 4'd7,
    OP_CMPLE = 4'd8,
    OP_MIN   = 4'd9,
    OP_MAX   = 4'd10,
    OP_SLL   = 4'd11,
    OP_SRL   = 4'd12,
    OP_SRA   = 4'd13
  } simd_op_e;

  typedef struct packed {
    simd_op_e        op;
    lane_width_e     width;
    logic            is_signed;
    logic [XLEN-1:0] operand_a;
    logic [XLEN-1:0] operand_b;
  } simd_req_t;

  typedef struct packed {
    logic [XLEN-1:0] result;
    logic            overflow;  // any lane clamped on SADD/SSUB
  } simd_rsp_t;

  // One flag per byte slice
  typedef logic [NUM_BYTES-1:0] lane_flags_t;

  // Copy the flag held by each lane's top byte into every byte of that lane
  function automatic lane_flags_t lane_from_top(input lane_flags_t top,
                                                input lane_width_e width);
    lane_flags_t spread;
    unique case (width)
      LW_8:    spread = top;
      LW_16:   spread = {{2{top[3]}}, {2{top[1]}}};
      default: spread = {NUM_BYTES{top[NUM_BYTES-1]}};
    endcase
    return spread;
  endfunction

endpackage

// ==== project.f ====
+incdir+test
logic/simd_pkg.sv
logic/simd_lane_adder.sv
logic/simd_lane_compare.sv
logic/simd_lane_shifter.sv
logic/simd_alu_top.sv
test/simd_alu_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the SIMD ALU testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -j 0 -f project.f --top-module simd_alu_tb \
  -o simd_alu_sim > build.log 2>&1 || { echo "Build failed, see build.log"; exit 1; }
./obj_dir/simd_alu_sim > sim.log 2>&1
grep -qx "sim passed" sim.log && echo "PASS" || { echo "FAIL, see sim.log"; exit 1; }

// ==== test/simd_alu_model.svh ====
/*
 * Packed-SIMD unit reference model
 * Lane-rule model of the response, plus the Galois LFSR step for stimulus
 */
`ifndef SIMD_ALU_MODEL_SVH
`define SIMD_ALU_MODEL_SVH

// Galois LFSR with taps x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
  return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
endfunction

function automatic int lane_bits(input simd_pkg::lane_width_e w);
  case (w)
    simd_pkg::LW_8:  return 8;
    simd_pkg::LW_16: return 16;
    default:         return 32;
  endcase
endfunction

function automatic simd_pkg::simd_rsp_t simd_model(input simd_pkg::simd_req_t req);
  simd_pkg::simd_rsp_t rsp;
  int                  lw;
  int                  amt;
  longint              m;
  longint              ua;
  longint              ub;
  longint              sa;
  longint              sb;
  longint              a;
  longint              b;
  longint              r;
  longint              lo;
  longint              hi;
  rsp = '0;
  lw  = lane_bits(req.width);
  m   = (longint'(1) << lw) - 1;
  for (int l = 0; l < 32 / lw; l++) begin
    ua  = longint'(req.operand_a >> (l * lw)) & m;
    ub  = longint'(req.operand_b >> (l * lw)) & m;
    // Two's complement view of the lane
    sa  = (ua > (m >> 1)) ? ua - m - 1 : ua;
    sb  = (ub > (m >> 1)) ? ub - m - 1 : ub;
    a   = req.is_signed ? sa : ua;
    b   = req.is_signed ? sb : ub;
    lo  = req.is_signed ? -(m >> 1) - 1 : longint'(0);
    hi  = req.is_signed ? (m >> 1) : m;
    amt = int'(ub & longint'(lw - 1));
    case (req.op)
      simd_pkg::OP_ADD, simd_pkg::OP_SADD: r = a + b;
      simd_pkg::OP_SUB, simd_pkg::OP_SSUB: r = a - b;
      simd_pkg::OP_HADD:  r = (a + b) >>> 1;
      simd_pkg::OP_HSUB:  r = (a - b) >>> 1;
      simd_pkg::OP_CMPEQ: r = (a == b) ? m : longint'(0);
      simd_pkg::OP_CMPLT: r = (a < b) ? m : longint'(0);
      simd_pkg::OP_CMPLE: r = (a <= b) ? m : longint'(0);
      simd_pkg::OP_MIN:   r = (a < b) ? a : b;
      simd_pkg::OP_MAX:   r = (a < b) ? b : a;
      simd_pkg::OP_SLL:   r = ua << amt;
      simd_pkg::OP_SRL:   r = ua >> amt;
      simd_pkg::OP_SRA:   r = sa >>> amt;
      default:            r = longint'(0);
    endcase
    // Clamp to the lane range on saturating ops only
    if (req.op == simd_pkg::OP_SADD || req.op == simd_pkg::OP_SSUB) begin
      if (r > hi || r < lo) begin
        rsp.overflow = 1'b1;
      end
      r = (r > hi) ? hi : (r < lo) ? lo : r;
    end
    rsp.result = rsp.result | 32'((r & m) << (l * lw));
  end
  return rsp;
endfunction

`endif

// ==== test/simd_alu_tb.sv ====
/*
 * Testbench for the packed-SIMD arithmetic unit
 * Directed and LFSR-driven requests checked against the lane-rule reference model
 */
module simd_alu_tb;

  localparam int NUM_SAT  = 48;
  localparam int NUM_CMP  = 120;
  localparam int NUM_SFT  = 27;
  localparam int NUM_WRAP = 144;
  localparam int NUM_RAND = 300;
  localparam int NUM_REQS = NUM_SAT + NUM_CMP + NUM_SFT + NUM_WRAP + NUM_RAND;

  logic                clk;
  logic                rst_n;
  logic                req_valid;
  simd_pkg::simd_req_t req;
  logic                rsp_valid;
  simd_pkg::simd_rsp_t rsp;
  logic [31:0]         lfsr;
  simd_pkg::simd_rsp_t exp_q[$];
  string               name_q[$];
  int                  got;
  logic                strobe_q;

  `include "simd_alu_model.svh"

  simd_alu_top simd_alu_top_i (
    .clk_i       (clk),
    .rst_n_i     (rst_n),
    .req_valid_i (req_valid),
    .req_i       (req),
    .rsp_valid_o (rsp_valid),
    .rsp_o       (rsp)
  );

  always #5 clk = ~clk;

  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v    = {v[30:0], lfsr[0]};
      lfsr = lfsr_next(lfsr);
    end
    return v;
  endfunction

  // Same value in every lane
  function automatic logic [31:0] lane_fill(input simd_pkg::lane_width_e w, input longint v);
    logic [31:0] r;
    int          lw;
    lw = lane_bits(w);
    r  = '0;
    for (int l = 0; l < 32 / lw; l++) begin
      r = r | 32'((v & ((longint'(1) << lw) - 1)) << (l * lw));
    end
    return r;
  endfunction

  task automatic issue(input simd_pkg::simd_op_e op, input simd_pkg::lane_width_e w,
                       input logic sgn, input logic [31:0] a, input logic [31:0] b,
                       input string name);
    simd_pkg::simd_req_t r;
    r.op        = op;
    r.width     = w;
    r.is_signed = sgn;
    r.operand_a = a;
    r.operand_b = b;
    @(posedge clk);
    #1;
    req_valid = 1'b1;
    req       = r;
    exp_q.push_back(simd_model(r));
    name_q.push_back(name);
  endtask

  task automatic idle_cycle();
    @(posedge clk);
    #1;
    req_valid = 1'b0;
  endtask

  // Strobe seen at the last rising edge
  always @(posedge clk) begin
    strobe_q <= rst_n && req_valid;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Response checker that pops one queue entry per valid cycle
  ////////////////////////////////////////////////////////////////////////////

  always @(negedge clk) begin
    simd_pkg::simd_rsp_t exp;
    string               name;
    if (rst_n) begin
      assert (rsp_valid === strobe_q) else begin
        $display("Response valid is %b but the strobe one cycle earlier was %b at time %0t",
                 rsp_valid, strobe_q, $time);
        $display("sim failed");
        $fatal(1);
      end
    end
    if (rst_n && rsp_valid) begin
      assert (exp_q.size() != 0) else begin
        $display("Response valid with no request outstanding at time %0t", $time);
        $display("sim failed");
        $fatal(1);
      end
      exp  = exp_q.pop_front();
      name = name_q.pop_front();
      assert (rsp === exp) else begin
        $display("FAILED %s expected %h ovf %b actual %h ovf %b",
                 name, exp.result, exp.overflow, rsp.result, rsp.overflow);
        $display("sim failed");
        $fatal(1);
      end
      got++;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    simd_pkg::simd_op_e    wrap_ops[4];
    simd_pkg::simd_op_e    cmp_ops[5];
    simd_pkg::simd_op_e    sft_ops[3];
    simd_pkg::lane_width_e w;
    logic [31:0]           x;
    logic [31:0]           pa[4];
    logic [31:0]           pb[4];
    longint                half;
    wrap_ops  = '{simd_pkg::OP_ADD, simd_pkg::OP_SUB, simd_pkg::OP_HADD, simd_pkg::OP_HSUB};
    cmp_ops   = '{simd_pkg::OP_CMPEQ, simd_pkg::OP_CMPLT, simd_pkg::OP_CMPLE,
                  simd_pkg::OP_MIN, simd_pkg::OP_MAX};
    sft_ops   = '{simd_pkg::OP_SLL, simd_pkg::OP_SRL, simd_pkg::OP_SRA};
    clk       = 1'b0;
    rst_n     = 1'b0;
    req_valid = 1'b0;
    req       = '0;
    lfsr      = 32'h2f32;
    got       = 0;
    repeat (2) @(posedge clk);
    #1;
    rst_n = 1'b1;
    assert (!rsp_valid && rsp == '0) else begin
      $display("Response register not cleared by reset");
      $display("sim failed");
      $fatal(1);
    end

    for (int wi = 0; wi < 3; wi++) begin
      w    = simd_pkg::lane_width_e'(2'(wi));
      half = longint'(1) << (lane_bits(w) - 1);
      for (int s = 0; s < 2; s++) begin
        foreach (wrap_ops[o]) begin
          repeat (6) begin
            issue(wrap_ops[o], w, 1'(s), take_bits(32), take_bits(32), "wrap_half");
          end
        end
        // Lane max, lane min, all ones and zero against one
        pa = '{lane_fill(w, half - 1), lane_fill(w, half), lane_fill(w, -1), 32'h0};
        for (int k = 0; k < 4; k++) begin
          issue(simd_pkg::OP_SADD, w, 1'(s), pa[k], lane_fill(w, 1), "sat_edge");
          issue(simd_pkg::OP_SSUB, w, 1'(s), pa[k], lane_fill(w, 1), "sat_edge");
        end
        foreach (cmp_ops[o]) begin
          x  = take_bits(32);
          pa = '{x, lane_fill(w, half), lane_fill(w, half - 1), take_bits(32)};
          pb = '{x, lane_fill(w, half - 1), lane_fill(w, half), take_bits(32)};
          for (int k = 0; k < 4; k++) begin
            issue(cmp_ops[o], w, 1'(s), pa[k], pb[k], "compare_minmax");
          end
        end
      end
      foreach (sft_ops[o]) begin
        issue(sft_ops[o], w, 1'(take_bits(1)), take_bits(32), lane_fill(w, 0), "shift_zero");
        issue(sft_ops[o], w, 1'(take_bits(1)), take_bits(32),
              lane_fill(w, lane_bits(w) - 1), "shift_max");
        issue(sft_ops[o], w, 1'(take_bits(1)), take_bits(32), take_bits(32), "shift_rand");
      end
    end

    // Random mix with occasional gaps between strobes
    repeat (NUM_RAND) begin
      if (take_bits(2) == 0) begin
        idle_cycle();
      end
      issue(simd_pkg::simd_op_e'(4'(take_bits(4) % 14)),
            simd_pkg::lane_width_e'(2'(take_bits(2) % 3)),
            1'(take_bits(1)), take_bits(32), take_bits(32), "random");
    end
    idle_cycle();

    while (exp_q.size() != 0) begin
      @(posedge clk);
    end
    repeat (2) @(posedge clk);
    if (got == NUM_REQS) begin
      $display("sim passed");
      $finish;
    end else begin
      $display("Received %0d responses for %0d requests", got, NUM_REQS);
      $display("sim failed");
      $fatal(1);
    end
  end

  // Two cycles per request to allow for gaps, plus reset and drain
  initial begin
    #((NUM_REQS * 2 + 20) * 10);
    $display("Timeout, responses did not arrive in time");
    $display("sim failed");
    $fatal(1);
  end

endmodule
